// ==== common/adc_cmd_pkg.sv ====
package adc_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // Command word layout
  ////////////////////////////////////////////////////////////

  localparam int COUNT_W  = 26;  // Delay or trigger count width
  localparam int OP_LSB   = 29;  // Opcode sits in bits 31:29
  localparam int TRIG_BIT = 28;  // Wait for triggers instead of a delay
  localparam int CONT_BIT = 27;  // Another command is expected

  // Command opcodes
  typedef enum logic [2:0] {
    OP_NO_OP   = 3'b000,
    OP_LOOP    = 3'b001,  // Still decoded so it can be rejected
    OP_ADC_RD  = 3'b010,
    OP_SET_ORD = 3'b100,
    OP_CANCEL  = 3'b111
  } cmd_op_e;

  // Decoded buffer head word
  typedef struct packed {
    cmd_op_e            op;
    logic               trig;
    logic               cont;
    logic [COUNT_W-1:0] count;
    logic [7:0][2:0]    order;  // Slot 0 in the low bits
    logic               valid;  // Buffer not empty
  } cmd_t;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_ADC_RD,
    S_ERROR
  } seq_state_e;

  // Sticky error flags
  typedef struct packed {
    logic unexp_trig;
    logic delay_too_short;
    logic bad_cmd;
    logic cmd_buf_underflow;
    logic data_buf_overflow;
  } err_t;

endpackage

// ==== common/adc_spi_pkg.sv ====
package adc_spi_pkg;

  ////////////////////////////////////////////////////////////
  // On-the-fly SPI frame format
  ////////////////////////////////////////////////////////////

  localparam int FRAME_BITS = 16;   // Bits per SPI frame
  localparam int ADC_WORDS  = 9;    // Eight requests plus one trailing frame

  localparam logic [1:0] OTF_PREFIX = 2'b10;  // On-the-fly sample request marker

  // ADC input channel
  typedef logic [2:0] chan_t;

  // One 16-bit reply from the ADC
  typedef logic [FRAME_BITS-1:0] sample_t;

  // Frame request from the sequencer to the SPI engine
  typedef struct packed {
    logic  start;  // Single-cycle pulse
    chan_t chan;   // Channel to request in this frame
  } frame_req_t;

endpackage

// ==== src/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
  input  logic              clk,
  input  logic              resetn,
  input  logic [31:0]       cmd_buf_word,
  input  logic              cmd_buf_empty,
  output adc_cmd_pkg::cmd_t cmd,
  output logic              bad_op
);

  logic [31:0] word;  // Head word, zero when the buffer is empty

  assign word = cmd_buf_empty ? 32'd0 : cmd_buf_word;

  ////////////////////////////////////////////////////////////
  // Field slicing
  ////////////////////////////////////////////////////////////

  always_comb begin
    cmd.op    = adc_cmd_pkg::cmd_op_e'(word[adc_cmd_pkg::OP_LSB +: 3]);
    cmd.trig  = word[adc_cmd_pkg::TRIG_BIT];
    cmd.cont  = word[adc_cmd_pkg::CONT_BIT];
    cmd.count = word[adc_cmd_pkg::COUNT_W-1:0];  // Delay or trigger count
    cmd.order = word[23:0];                      // Eight 3-bit slots, slot 0 lowest
    cmd.valid = !cmd_buf_empty;
  end

  // Loop and unassigned opcodes are rejected
  always_comb begin
    case (cmd.op)
      adc_cmd_pkg::OP_NO_OP,
      adc_cmd_pkg::OP_ADC_RD,
      adc_cmd_pkg::OP_SET_ORD,
      adc_cmd_pkg::OP_CANCEL: bad_op = 1'b0;
      default:                bad_op = 1'b1;
    endcase
  end

  // An empty buffer must never be reported as a bad command
  a_bad_op_needs_valid : assert property (
    @(posedge clk) disable iff (!resetn)
    bad_op |-> cmd.valid
  );

endmodule

// ==== sequencer/adc_sequencer.sv ====
`timescale 1ns/1ps

module adc_sequencer (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_cmd_pkg::cmd_t       cmd,
  input  logic                    bad_op,
  input  logic                    trigger,
  input  logic                    frame_done,
  input  logic                    overflow,
  output logic                    cmd_buf_rd_en,
  output logic                    waiting_for_trig,
  output adc_spi_pkg::frame_req_t frame_req,
  output logic                    capture,
  output adc_cmd_pkg::err_t       err
);

  localparam int               IDX_W    = $clog2(adc_spi_pkg::ADC_WORDS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(adc_spi_pkg::ADC_WORDS - 1);

  adc_cmd_pkg::seq_state_e         state;
  adc_cmd_pkg::seq_state_e         state_nxt;
  adc_cmd_pkg::seq_state_e         issue_state;  // Where the head command leads
  logic [adc_cmd_pkg::COUNT_W-1:0] delay_timer;
  logic [adc_cmd_pkg::COUNT_W-1:0] trig_cnt;
  logic                            wait_trig;    // Latched trig bit
  logic                            expect_next;  // Latched cont bit
  adc_spi_pkg::chan_t [7:0]        ord;          // Sample order table
  logic [IDX_W-1:0]                frame_idx;
  logic                            last_done;
  logic                            finish;
  logic                            cancel_wait;
  adc_cmd_pkg::err_t               err_set;

  ////////////////////////////////////////////////////////////
  // Command completion
  ////////////////////////////////////////////////////////////

  assign last_done = (state == adc_cmd_pkg::S_ADC_RD) && frame_done
                     && (frame_idx == LAST_IDX);  // Ninth frame ends

  // Cancel aborts any wait, including the one after a read
  assign cancel_wait = ((state == adc_cmd_pkg::S_DELAY) || (state == adc_cmd_pkg::S_TRIG_WAIT))
                       && cmd.valid && (cmd.op == adc_cmd_pkg::OP_CANCEL);

  assign finish = ((state == adc_cmd_pkg::S_IDLE) && cmd.valid)
                  || ((state == adc_cmd_pkg::S_DELAY) && (delay_timer == '0))
                  || ((state == adc_cmd_pkg::S_TRIG_WAIT) && trigger
                      && (trig_cnt <= adc_cmd_pkg::COUNT_W'(1)))  // N-th trigger
                  || (last_done && !wait_trig && (delay_timer == '0));

  // Errors detected here, bad_op and overflow only registered
  always_comb begin
    err_set = '0;
    if (state != adc_cmd_pkg::S_ERROR) begin
      err_set.unexp_trig        = trigger && (state != adc_cmd_pkg::S_TRIG_WAIT);
      err_set.delay_too_short   = (state == adc_cmd_pkg::S_ADC_RD) && !wait_trig
                                  && (delay_timer == '0) && !last_done;
      err_set.bad_cmd           = finish && bad_op;
      err_set.cmd_buf_underflow = finish && !cmd.valid && expect_next;
      err_set.data_buf_overflow = overflow;
    end
  end

  // Pop the head word, never in a cycle that raises an error
  assign cmd_buf_rd_en = ((finish && cmd.valid) || cancel_wait) && !(|err_set);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (cmd.op)
      adc_cmd_pkg::OP_NO_OP:  issue_state = cmd.trig ? adc_cmd_pkg::S_TRIG_WAIT
                                                     : adc_cmd_pkg::S_DELAY;
      adc_cmd_pkg::OP_ADC_RD: issue_state = adc_cmd_pkg::S_ADC_RD;
      default:                issue_state = adc_cmd_pkg::S_IDLE;  // Set order, cancel
    endcase
  end

  always_comb begin
    state_nxt = state;
    if (|err_set) begin
      state_nxt = adc_cmd_pkg::S_ERROR;
    end else if (cancel_wait) begin
      state_nxt = adc_cmd_pkg::S_IDLE;
    end else if (finish) begin
      state_nxt = cmd.valid ? issue_state : adc_cmd_pkg::S_IDLE;
    end else if (last_done) begin
      // Read over, wait out the rest of the command
      state_nxt = wait_trig ? adc_cmd_pkg::S_TRIG_WAIT : adc_cmd_pkg::S_DELAY;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state            <= adc_cmd_pkg::S_IDLE;
      waiting_for_trig <= 1'b0;
      err              <= '0;
    end else begin
      state            <= state_nxt;
      waiting_for_trig <= (state_nxt == adc_cmd_pkg::S_TRIG_WAIT);
      err              <= err | err_set;  // Sticky until reset
    end
  end

  ////////////////////////////////////////////////////////////
  // Delay timer, trigger counter and command latches
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_timer <= '0;
      trig_cnt    <= '0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (cmd_buf_rd_en) begin
      if ((cmd.op == adc_cmd_pkg::OP_NO_OP) || (cmd.op == adc_cmd_pkg::OP_ADC_RD)) begin
        wait_trig   <= cmd.trig;
        expect_next <= cmd.cont;
        // Loaded with N-1 so the delay ends N cycles after issue
        delay_timer <= (cmd.trig || (cmd.count == '0)) ? '0 : cmd.count - 1'b1;
        trig_cnt    <= cmd.trig ? cmd.count : '0;
      end else begin
        wait_trig   <= 1'b0;
        expect_next <= 1'b0;
        delay_timer <= '0;
        trig_cnt    <= '0;
      end
    end else begin
      if (delay_timer != '0) delay_timer <= delay_timer - 1'b1;  // Runs through the read too
      if ((state == adc_cmd_pkg::S_TRIG_WAIT) && trigger && (trig_cnt != '0)) begin
        trig_cnt <= trig_cnt - 1'b1;
      end
    end
  end

  // Identity order out of reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 8; i++) ord[i] <= adc_spi_pkg::chan_t'(i);
    end else if (cmd_buf_rd_en && (cmd.op == adc_cmd_pkg::OP_SET_ORD)) begin
      ord <= cmd.order;
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_req.start <= 1'b0;
      frame_req.chan  <= '0;
      frame_idx       <= '0;
    end else begin
      frame_req.start <= 1'b0;  // Pulse
      if (cmd_buf_rd_en && (cmd.op == adc_cmd_pkg::OP_ADC_RD)) begin
        frame_req.start <= 1'b1;
        frame_req.chan  <= ord[0];
        frame_idx       <= '0;
      end else if ((state == adc_cmd_pkg::S_ADC_RD) && frame_done
                   && (frame_idx != LAST_IDX) && !(|err_set)) begin
        frame_req.start <= 1'b1;
        frame_idx       <= frame_idx + 1'b1;
        // Trailing frame only collects the last reply
        frame_req.chan  <= (frame_idx == LAST_IDX - 1'b1) ? '0 : ord[frame_idx[2:0] + 3'd1];
      end
    end
  end

  // Replies lag one frame, so the first frame carries nothing
  assign capture = (state == adc_cmd_pkg::S_ADC_RD) && (frame_idx != '0);

  // Only a trig no-op or a trig read can lead into the trigger wait
  a_wait_only_in_trig : assert property (
    @(posedge clk) disable iff (!resetn)
    waiting_for_trig |-> ((state == adc_cmd_pkg::S_TRIG_WAIT) && wait_trig)
  );

  a_error_sticky : assert property (
    @(posedge clk) disable iff (!resetn)
    (state == adc_cmd_pkg::S_ERROR) |=> (state == adc_cmd_pkg::S_ERROR)
  );

endmodule

// ==== spi/spi_frame_engine.sv ====
`timescale 1ns/1ps

module spi_frame_engine #(
  parameter int CS_HIGH_CYCLES = 4  // Must be at least 1
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_spi_pkg::frame_req_t frame_req,
  output logic                    n_cs,
  output logic                    mosi,
  input  logic                    miso,
  output logic                    frame_done,
  output adc_spi_pkg::sample_t    reply,
  output logic                    reply_valid
);

  localparam int FB    = adc_spi_pkg::FRAME_BITS;
  localparam int CS_W  = $clog2(CS_HIGH_CYCLES + 1);
  localparam int BIT_W = $clog2(FB);

  logic            cs_wait;   // n_cs high phase before the frame
  logic [CS_W-1:0] cs_cnt;
  logic [BIT_W-1:0] bit_cnt;  // Bit position within the low phase
  logic [FB-1:0]   mosi_sr;
  logic [FB-2:0]   miso_sr;   // Last bit comes straight from the pin

  ////////////////////////////////////////////////////////////
  // Chip select and bit timing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cs_wait <= 1'b0;
      cs_cnt  <= '0;
      bit_cnt <= '0;
      n_cs    <= 1'b1;
    end else if (frame_req.start) begin
      cs_wait <= 1'b1;
      cs_cnt  <= CS_W'(CS_HIGH_CYCLES - 1);
    end else if (cs_wait) begin
      if (cs_cnt == '0) begin
        cs_wait <= 1'b0;
        n_cs    <= 1'b0;  // Frame starts
        bit_cnt <= '0;
      end else begin
        cs_cnt <= cs_cnt - 1'b1;
      end
    end else if (!n_cs) begin
      if (frame_done) n_cs <= 1'b1;  // Rises right after the last bit
      else bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign frame_done = !n_cs && (bit_cnt == BIT_W'(FB - 1));

  ////////////////////////////////////////////////////////////
  // Shift registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (frame_req.start) begin
      // Prefix, channel, then zeros
      mosi_sr <= {adc_spi_pkg::OTF_PREFIX, frame_req.chan, {(FB - 5){1'b0}}};
    end else if (!n_cs) begin
      mosi_sr <= {mosi_sr[FB-2:0], 1'b0};
    end
  end

  assign mosi = mosi_sr[FB-1];  // MSB first

  always_ff @(posedge clk) begin
    if (!n_cs) miso_sr <= {miso_sr[FB-3:0], miso};  // Sampled in the same cycles as MOSI
  end

  assign reply       = {miso_sr, miso};
  assign reply_valid = frame_done;

  // Requests are spaced by the sequencer, never mid-frame
  a_no_start_in_frame : assert property (
    @(posedge clk) disable iff (!resetn)
    frame_req.start |-> (!cs_wait && n_cs)
  );

endmodule

// ==== src/sample_packer.sv ====
`timescale 1ns/1ps

module sample_packer (
  input  logic                 clk,
  input  logic                 resetn,
  input  adc_spi_pkg::sample_t reply,
  input  logic                 reply_valid,
  input  logic                 capture,
  input  logic                 data_buf_full,
  output logic                 data_buf_wr_en,
  output logic [31:0]          data_word,
  output logic                 overflow
);

  adc_spi_pkg::sample_t held;    // Earlier reply of the pair
  logic                 stored;  // Lower half is waiting
  logic                 take;

  assign take = capture && reply_valid;

  ////////////////////////////////////////////////////////////
  // Pairing and buffer write
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      stored         <= 1'b0;
      data_buf_wr_en <= 1'b0;
      overflow       <= 1'b0;
    end else begin
      data_buf_wr_en <= take && stored && !data_buf_full;
      overflow       <= take && stored && data_buf_full;  // Word dropped, no stall
      if (!capture) stored <= 1'b0;  // Read over or aborted
      else if (reply_valid) stored <= !stored;
    end
  end

  always_ff @(posedge clk) begin
    if (take && !stored) held <= reply;
    if (take && stored) data_word <= {reply, held};  // Later reply on top
  end

endmodule

// ==== src/adc_ctrl_top.sv ====
`timescale 1ns/1ps

module adc_ctrl_top #(
  parameter int CS_HIGH_CYCLES = 4  // n_cs high time before each frame
) (
  input  logic                    clk,
  input  logic                    resetn,
  // Command buffer
  input  logic [31:0]             cmd_buf_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_buf_rd_en,
  // Data buffer
  output logic                    data_buf_wr_en,
  output logic [31:0]             data_word,
  input  logic                    data_buf_full,
  // Trigger
  input  logic                    trigger,
  output logic                    waiting_for_trig,
  // SPI
  output logic                    n_cs,
  output logic                    mosi,
  input  logic                    miso,
  // Sticky errors
  output adc_cmd_pkg::err_t       err
);

  adc_cmd_pkg::cmd_t       cmd;          // Decoded buffer head
  logic                    bad_op;
  adc_spi_pkg::frame_req_t frame_req;
  logic                    frame_done;
  adc_spi_pkg::sample_t    reply;
  logic                    reply_valid;
  logic                    capture;      // Replies of frames 2 to 9 count
  logic                    overflow;

  cmd_decode i_cmd_decode (
    .clk           (clk),
    .resetn        (resetn),
    .cmd_buf_word  (cmd_buf_word),
    .cmd_buf_empty (cmd_buf_empty),
    .cmd           (cmd),
    .bad_op        (bad_op)
  );

  adc_sequencer i_adc_sequencer (
    .clk              (clk),
    .resetn           (resetn),
    .cmd              (cmd),
    .bad_op           (bad_op),
    .trigger          (trigger),
    .frame_done       (frame_done),
    .overflow         (overflow),
    .cmd_buf_rd_en    (cmd_buf_rd_en),
    .waiting_for_trig (waiting_for_trig),
    .frame_req        (frame_req),
    .capture          (capture),
    .err              (err)
  );

  spi_frame_engine #(
    .CS_HIGH_CYCLES (CS_HIGH_CYCLES)
  ) i_spi_frame_engine (
    .clk         (clk),
    .resetn      (resetn),
    .frame_req   (frame_req),
    .n_cs        (n_cs),
    .mosi        (mosi),
    .miso        (miso),
    .frame_done  (frame_done),
    .reply       (reply),
    .reply_valid (reply_valid)
  );

  sample_packer i_sample_packer (
    .clk            (clk),
    .resetn         (resetn),
    .reply          (reply),
    .reply_valid    (reply_valid),
    .capture        (capture),
    .data_buf_full  (data_buf_full),
    .data_buf_wr_en (data_buf_wr_en),
    .data_word      (data_word),
    .overflow       (overflow)
  );

endmodule

// ==== test/adc_spi_model.sv ====
`timescale 1ns/1ps

module adc_spi_model (
  input  logic clk,
  input  logic resetn,
  input  logic n_cs,
  input  logic mosi,
  output logic miso
);

  logic [3:0]  bit_idx;  // Bit position within the current frame
  logic [14:0] rx_sr;    // Request bits seen so far
  logic [15:0] req;      // Whole request, valid on the last bit
  logic [15:0] tx_word;  // Answer to the previous request

  // Last request bit comes straight from the pin
  assign req = {rx_sr, mosi};

  ////////////////////////////////////////////////////////////
  // Request capture, answer for the next frame
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!resetn) begin
      bit_idx <= '0;
      tx_word <= '0;
    end else if (!n_cs) begin
      rx_sr   <= {rx_sr[13:0], mosi};
      bit_idx <= bit_idx + 4'd1;  // Wraps to 0 after bit 15
      if (bit_idx == 4'd15) begin
        // Channel c answers with c copies in every nibble
        if (req[15:14] == adc_spi_pkg::OTF_PREFIX) tx_word <= {13'd0, req[13:11]} * 16'h1111;
        else tx_word <= '0;  // Not a sample request
      end
    end
  end

  // MSB first, idle low outside a frame
  assign miso = n_cs ? 1'b0 : tx_word[4'd15 - bit_idx];

endmodule

// ==== test/tb_adc_ctrl.sv ====
`timescale 1ns/1ps

module tb_adc_ctrl;

  localparam int NUM_TESTS     = 8;
  localparam int REC_W         = 15;    // Words per test record
  localparam int WAIT_LIMIT    = 5000;  // Cycles before a wait gives up
  localparam int SETTLE_CYCLES = 40;    // Quiet window after a test ends
  // Record fields
  localparam int F_NCMD   = 0;
  localparam int F_CMD    = 1;
  localparam int F_PULSES = 5;
  localparam int F_FLAGS  = 6;
  localparam int F_WORDS  = 7;
  localparam int F_STATUS = 8;
  localparam int F_FRAMES = 9;
  localparam int F_LEFT   = 10;
  localparam int F_DATA   = 11;

  logic              clk;
  logic              resetn        = 1'b0;
  logic [31:0]       cmd_buf_word  = '0;
  logic              cmd_buf_empty = 1'b1;
  logic              cmd_buf_rd_en;
  logic              data_buf_wr_en;
  logic [31:0]       data_word;
  logic              data_buf_full = 1'b0;
  logic              trigger       = 1'b0;
  logic              waiting_for_trig;
  logic              n_cs;
  logic              mosi;
  logic              miso;
  adc_cmd_pkg::err_t err;

  logic [31:0] tests_mem [0:NUM_TESTS*REC_W-1];
  logic [31:0] cmd_q [$];       // Command buffer contents
  logic [31:0] data_q [$];      // Words written to the data buffer
  logic [31:0] seed = 32'd74;
  logic        n_cs_prev = 1'b1;
  logic        saw_wait;        // waiting_for_trig seen high
  int          frames;          // n_cs falling edges
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  adc_ctrl_top #(
    .CS_HIGH_CYCLES (4)
  ) i_adc_ctrl_top (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_buf_word     (cmd_buf_word),
    .cmd_buf_empty    (cmd_buf_empty),
    .cmd_buf_rd_en    (cmd_buf_rd_en),
    .data_buf_wr_en   (data_buf_wr_en),
    .data_word        (data_word),
    .data_buf_full    (data_buf_full),
    .trigger          (trigger),
    .waiting_for_trig (waiting_for_trig),
    .n_cs             (n_cs),
    .mosi             (mosi),
    .miso             (miso),
    .err              (err)
  );

  adc_spi_model i_adc_spi_model (
    .clk    (clk),
    .resetn (resetn),
    .n_cs   (n_cs),
    .mosi   (mosi),
    .miso   (miso)
  );

  ////////////////////////////////////////////////////////////
  // Buffer models and monitors, all on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (cmd_buf_rd_en) begin
      if (cmd_q.size() == 0) begin
        $display("Command buffer was read while empty");
        err_cnt++;
      end else begin
        cmd_q.delete(0);  // Word consumed in the strobe cycle
      end
    end
    if (cmd_q.size() != 0) begin
      cmd_buf_word  <= cmd_q[0];
      cmd_buf_empty <= 1'b0;
    end else begin
      cmd_buf_word  <= '0;
      cmd_buf_empty <= 1'b1;
    end
  end

  always @(posedge clk) begin
    if (data_buf_wr_en) begin
      if (data_buf_full) begin
        $display("Data buffer was written while full");
        err_cnt++;
      end else begin
        data_q.push_back(data_word);
      end
    end
    if (n_cs_prev && !n_cs) frames++;  // Frame start
    n_cs_prev = n_cs;
    if (waiting_for_trig) saw_wait = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Four cycles low, buffers and monitors cleared meanwhile
  task automatic apply_reset(input logic full);
    @(posedge clk);
    resetn        <= 1'b0;
    trigger       <= 1'b0;
    data_buf_full <= full;  // Held for the whole test
    @(negedge clk);
    cmd_q.delete();
    data_q.delete();
    frames   = 0;
    saw_wait = 1'b0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
    @(negedge clk);
  endtask

  task automatic trigger_when_waiting();
    int n;
    n = 0;
    @(negedge clk);
    while (!waiting_for_trig && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!waiting_for_trig) begin
      $display("Timeout: waiting_for_trig never went high");
      err_cnt++;
    end else begin
      pulse_trigger();
    end
  endtask

  task automatic wait_for_error();
    int n;
    n = 0;
    while (!(|err) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!(|err)) begin
      $display("Timeout: no error flag was raised");
      err_cnt++;
    end
  endtask

  task automatic wait_for_drain();
    int n;
    n = 0;
    while (cmd_q.size() != 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (cmd_q.size() != 0) begin
      $display("Timeout: the command buffer was never drained");
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One test record
  ////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    int          base;
    int          errs_before;
    int          i;
    logic [31:0] flags;
    logic [31:0] status;
    base        = t * REC_W;
    errs_before = err_cnt;
    flags       = tests_mem[base + F_FLAGS];
    status      = tests_mem[base + F_STATUS];  // Bit 8 wait seen, bits 4:0 err
    apply_reset(flags[0]);
    seed = lcg_next(seed);
    repeat (seed[18:16]) @(posedge clk);  // Random idle gap
    if (flags[1]) pulse_trigger();        // Trigger while idle
    @(negedge clk);
    for (i = 0; i < int'(tests_mem[base + F_NCMD]); i++) begin
      cmd_q.push_back(tests_mem[base + F_CMD + i]);
    end
    for (i = 0; i < int'(tests_mem[base + F_PULSES]); i++) trigger_when_waiting();
    if (status[4:0] != 5'd0) wait_for_error();
    else wait_for_drain();
    repeat (SETTLE_CYCLES) @(negedge clk);  // Nothing more may happen
    check_value("err", {27'd0, err}, {27'd0, status[4:0]});
    check_value("waiting_for_trig seen", {31'd0, saw_wait}, {31'd0, status[8]});
    check_value("waiting_for_trig", {31'd0, waiting_for_trig}, 32'd0);
    check_value("n_cs", {31'd0, n_cs}, 32'd1);
    check_value("frames", frames, tests_mem[base + F_FRAMES]);
    check_value("cmd_buf words left", cmd_q.size(), tests_mem[base + F_LEFT]);
    check_value("data_buf words", data_q.size(), tests_mem[base + F_WORDS]);
    for (i = 0; i < int'(tests_mem[base + F_WORDS]) && i < data_q.size(); i++) begin
      check_value($sformatf("data_word %0d", i), data_q[i], tests_mem[base + F_DATA + i]);
    end
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %0d passed", t);
    end else begin
      fail_cnt++;
      $display("test %0d failed", t);
    end
  endtask

  initial begin
    $readmemh("test/adc_tests.txt", tests_mem);
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== test/adc_tests.txt ====
// Stimulus line: ncmd cmd0 cmd1 cmd2 cmd3 trig_pulses flags (bit0 data_buf_full, bit1 idle trigger)
// Expect line: words status (bit8 wait seen, bits4:0 err) frames cmd_left word0 word1 word2 word3
// Set order 3,5,0,7,1,6,2,4 then read with a long delay
3 808B1E2B 40000400 00000001 00000000 0 0
4 000 9 0 55553333 77770000 66661111 44442222
// Read waiting for 2 triggers, then a short no-op
2 50000002 00000001 00000000 00000000 2 0
4 100 9 0 11110000 33332222 55554444 77776666
// No-op trigger wait, cancelled at once
2 10000005 E0000000 00000000 00000000 0 0
0 100 0 0 00000000 00000000 00000000 00000000
// Trigger in idle, read stays unread
1 40000400 00000000 00000000 00000000 0 2
0 010 0 1 00000000 00000000 00000000 00000000
// Read with a 10 cycle delay
1 4000000A 00000000 00000000 00000000 0 0
0 008 1 0 00000000 00000000 00000000 00000000
// Loop opcode
1 20000005 00000000 00000000 00000000 0 0
0 004 0 1 00000000 00000000 00000000 00000000
// No-op with cont and nothing after it
1 08000005 00000000 00000000 00000000 0 0
0 002 0 0 00000000 00000000 00000000 00000000
// Read into a full data buffer
1 40000400 00000000 00000000 00000000 0 1
0 001 4 0 00000000 00000000 00000000 00000000

// ==== build.f ====
common/adc_cmd_pkg.sv
common/adc_spi_pkg.sv
src/cmd_decode.sv
sequencer/adc_sequencer.sv
spi/spi_frame_engine.sv
src/sample_packer.sv
src/adc_ctrl_top.sv
test/adc_spi_model.sv
test/tb_adc_ctrl.sv

// ==== Bender.yml ====
package:
  name: adc_ctrl

sources:
  # Shared packages first
  - common/adc_cmd_pkg.sv
  - common/adc_spi_pkg.sv
  # RTL
  - src/cmd_decode.sv
  - sequencer/adc_sequencer.sv
  - spi/spi_frame_engine.sv
  - src/sample_packer.sv
  - src/adc_ctrl_top.sv
  # Testbench
  - target: test
    files:
      - test/adc_spi_model.sv
      - test/tb_adc_ctrl.sv
